// File: ternary_pkg.sv
// shared widths, constants and packed types for the ternary outer-product accumulator
// every design file refers to these by scoped name
`default_nettype none

package ternary_pkg;

    // five base-3 digits fit in one byte since 3^5 = 243
    localparam int TRITS_PER_BYTE = 5;

    // highest code that is a real base-3 value; 243..255 decode as five +1 weights
    localparam int MAX_PACKED_CODE = 242;

    // accumulator width, results wrap at this size
    localparam int ACC_W = 17;

    // lowest accumulator bit that shows up in a readout byte
    localparam int OUT_LSB = 8;

    // one signed activation
    typedef logic signed [7:0] act_t;

    // one accumulator cell
    typedef logic signed [ACC_W-1:0] acc_t;

    // input beat, packed weights in the upper byte
    typedef struct packed {
        logic [7:0] weights;
        act_t       act;
    } in_beat_t;

    // decoded weights of one byte
    // zero set means skip, else sign 1 is -1 and sign 0 is +1
    typedef struct packed {
        logic [TRITS_PER_BYTE-1:0] zero;
        logic [TRITS_PER_BYTE-1:0] sign;
    } trit_vec_t;

endpackage

`default_nettype wire

// File: trit_unpack.sv
// combinational base-3 decoder, one packed weight byte to five ternary weights
// instantiated once per slice inside the operand collector
`default_nettype none

module trit_unpack (
    input  logic [7:0]             code,
    output ternary_pkg::trit_vec_t trits
);

    // running quotient and current digit of the base-3 expansion
    logic [7:0] rem;
    logic [1:0] digit;

    always_comb begin
        rem   = code;
        digit = 2'd0;
        trits = '0;
        // least significant digit lands in bit 4, weight-81 digit in bit 0
        for (int d = 0; d < ternary_pkg::TRITS_PER_BYTE; d++) begin
            digit = 2'(rem % 8'd3);
            rem   = rem / 8'd3;
            // digit 0 is a zero weight
            trits.zero[ternary_pkg::TRITS_PER_BYTE-1-d] = (digit == 2'd0);
            // digit 2 is -1, digit 1 is +1
            trits.sign[ternary_pkg::TRITS_PER_BYTE-1-d] = (digit == 2'd2);
        end
        // out of range codes, all masks clear gives five +1 weights
        if (code > 8'(ternary_pkg::MAX_PACKED_CODE)) begin
            trits = '0;
        end
    end

endmodule

`default_nettype wire

// File: operand_collector.sv
// gathers SLICES input beats into one operand group for the MAC array
// group_valid pulses for one cycle after the last beat; flush restarts the count
`default_nettype none

module operand_collector #(
    parameter int SLICES = 2
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                in_valid,
    input  ternary_pkg::in_beat_t               in_beat,
    input  logic                                flush,
    output logic                                group_valid,
    output ternary_pkg::trit_vec_t [SLICES-1:0] group_trits,
    output ternary_pkg::act_t      [SLICES-1:0] group_acts
);

    localparam int CNT_W = (SLICES > 1) ? $clog2(SLICES) : 1;

    // slice index of the next accepted beat
    logic [CNT_W-1:0] slice_cnt;

    // one stored beat per slice
    ternary_pkg::in_beat_t [SLICES-1:0] slots_q;

    logic accept;
    logic last_beat;

    // a beat that arrives with flush is dropped
    assign accept    = in_valid && !flush;
    assign last_beat = accept && (slice_cnt == CNT_W'(SLICES - 1));

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            slice_cnt <= '0;
        end else if (accept) begin
            slice_cnt <= last_beat ? '0 : slice_cnt + 1'b1;
        end
    end

    // group is complete in the cycle after its last beat
    always_ff @(posedge clk) begin
        if (reset) begin
            group_valid <= 1'b0;
        end else begin
            group_valid <= last_beat;
        end
    end

    // slot 0 may be overwritten on the edge that consumes the group,
    // the array samples the old contents on that same edge
    always_ff @(posedge clk) begin
        if (accept) begin
            slots_q[slice_cnt] <= in_beat;
        end
    end

    for (genvar s = 0; s < SLICES; s++) begin : g_slice
        trit_unpack unpack_i (
            .code  (slots_q[s].weights),
            .trits (group_trits[s])
        );
        assign group_acts[s] = slots_q[s].act;
    end

endmodule

`default_nettype wire

// File: mac_array.sv
// grid of 5*SLICES by SLICES ternary accumulators, one whole group per cycle
// acc_next is the value after this cycle's update, flush clears the registers
`default_nettype none

module mac_array #(
    parameter int SLICES = 2
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                group_valid,
    input  ternary_pkg::trit_vec_t [SLICES-1:0] group_trits,
    input  ternary_pkg::act_t      [SLICES-1:0] group_acts,
    input  logic                                flush,
    output ternary_pkg::acc_t [ternary_pkg::TRITS_PER_BYTE*SLICES*SLICES-1:0] acc_next
);

    localparam int ROWS = ternary_pkg::TRITS_PER_BYTE * SLICES;
    localparam int COLS = SLICES;

    // cell (i,j) lives at index i*COLS + j
    ternary_pkg::acc_t [ROWS*COLS-1:0] acc_q;

    for (genvar i = 0; i < ROWS; i++) begin : g_row
        // row i takes trit i mod 5 of slice i div 5
        localparam int SL = i / ternary_pkg::TRITS_PER_BYTE;
        localparam int K  = i % ternary_pkg::TRITS_PER_BYTE;

        ternary_pkg::trit_vec_t w;
        logic                   skip;

        assign w    = group_trits[SL];
        assign skip = !group_valid || w.zero[K];

        for (genvar j = 0; j < COLS; j++) begin : g_col
            ternary_pkg::acc_t addend;

            // column activation, sign extended to accumulator width
            assign addend = ternary_pkg::acc_t'($signed(group_acts[j]));

            // wraps at ACC_W bits
            assign acc_next[i*COLS+j] = skip      ? acc_q[i*COLS+j] :
                                        w.sign[K] ? acc_q[i*COLS+j] - addend :
                                                    acc_q[i*COLS+j] + addend;
        end
    end

    // flush hands acc_next to the queue on this edge and starts over from zero
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            acc_q <= '0;
        end else begin
            acc_q <= acc_next;
        end
    end

endmodule

`default_nettype wire

// File: readout_queue.sv
// snapshot of all accumulators taken on flush, streamed out as bytes under valid/ready
// each byte is bits 15..8 of one accumulator, in index order
`default_nettype none

module readout_queue #(
    parameter int SLICES = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  ternary_pkg::acc_t [ternary_pkg::TRITS_PER_BYTE*SLICES*SLICES-1:0] acc_next,
    output logic       out_valid,
    input  logic       out_ready,
    output logic [7:0] out_data
);

    localparam int DEPTH = ternary_pkg::TRITS_PER_BYTE * SLICES * SLICES;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // entry 0 is the head
    ternary_pkg::acc_t [DEPTH-1:0] queue_q;

    // entries still to be sent
    logic [CNT_W-1:0] count_q;

    logic xfer;

    assign out_valid = (count_q != '0);
    assign xfer      = out_valid && out_ready;
    assign out_data  = queue_q[0][ternary_pkg::OUT_LSB +: 8];

    // a flush mid-drain drops what is left and reloads
    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
        end else if (flush) begin
            count_q <= CNT_W'(DEPTH);
        end else if (xfer) begin
            count_q <= count_q - 1'b1;
        end
    end

    // parallel load, shift toward the head on every transfer
    always_ff @(posedge clk) begin
        if (flush) begin
            queue_q <= acc_next;
        end else if (xfer) begin
            queue_q <= {ternary_pkg::acc_t'(0), queue_q[DEPTH-1:1]};
        end
    end

endmodule

`default_nettype wire

// File: ternary_matmul.sv
// top level of the ternary outer-product accumulator
// beats go in through the collector, results leave through the readout queue
`default_nettype none

module ternary_matmul #(
    parameter int SLICES = 2
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  ternary_pkg::in_beat_t in_beat,
    input  logic                  flush,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [7:0]            out_data
);

    // collector to array
    logic                                group_valid;
    ternary_pkg::trit_vec_t [SLICES-1:0] group_trits;
    ternary_pkg::act_t      [SLICES-1:0] group_acts;

    // array to queue, updated accumulator values
    ternary_pkg::acc_t [ternary_pkg::TRITS_PER_BYTE*SLICES*SLICES-1:0] acc_next;

    operand_collector #(.SLICES(SLICES)) operand_collector_i (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_beat     (in_beat),
        .flush       (flush),
        .group_valid (group_valid),
        .group_trits (group_trits),
        .group_acts  (group_acts)
    );

    mac_array #(.SLICES(SLICES)) mac_array_i (
        .clk         (clk),
        .reset       (reset),
        .group_valid (group_valid),
        .group_trits (group_trits),
        .group_acts  (group_acts),
        .flush       (flush),
        .acc_next    (acc_next)
    );

    readout_queue #(.SLICES(SLICES)) readout_queue_i (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .acc_next  (acc_next),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// File: ternary_matmul_checker.sv
// concurrent checks on the readout handshake, the reset state and the group pulse
// attached to every ternary_matmul instance through bind
`default_nettype none

module ternary_matmul_checker (
    input logic       clk,
    input logic       reset,
    input logic       flush,
    input logic       group_valid,
    input logic       out_valid,
    input logic       out_ready,
    input logic [7:0] out_data
);
    timeunit 1ns;
    timeprecision 1ps;

    // queue empty in the cycle after any reset edge
    reset_clears_valid: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    // stalled head byte holds unless a flush reloads the queue
    stall_holds_data: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready && !flush) |=> $stable(out_data))
        else $error("out_data changed while stalled");

    // a group is presented for exactly one cycle
    group_single_cycle: assert property (@(posedge clk) disable iff (reset)
        group_valid |=> !group_valid)
        else $error("group_valid high for two cycles in a row");

endmodule

bind ternary_matmul ternary_matmul_checker checker_i (
    .clk         (clk),
    .reset       (reset),
    .flush       (flush),
    .group_valid (group_valid),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_data    (out_data)
);

`default_nettype wire

// File: tb_ternary_matmul.sv
// testbench for the ternary outer-product accumulator with a reference model in the bench
// random beats and flushes go in; every readout byte is compared with the model snapshot
`default_nettype none

module tb_ternary_matmul;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SLICES = 2;
    localparam int ROWS = ternary_pkg::TRITS_PER_BYTE * SLICES;
    localparam int DEPTH = ROWS * SLICES;
    localparam int CLK_PERIOD = 10;
    // test sizes, also used to bound the run time
    localparam int DECODE_REPS = 3;
    localparam int N_RAND = 40;
    localparam int N_WRAP = 600;
    localparam int N_GROUPS = (256 / SLICES) * DECODE_REPS + N_RAND + N_WRAP + 8;
    localparam int N_FLUSHES = 256 / SLICES + 10;
    localparam int DRAIN_LIMIT = 20 * DEPTH;
    localparam int WATCHDOG_CYCLES = N_GROUPS * (SLICES + 4) + N_FLUSHES * (DRAIN_LIMIT + 8) + 64;
    localparam int READY_PAT_LEN = 1024;

    logic clk = 1'b0;
    logic reset;
    logic in_valid;
    ternary_pkg::in_beat_t in_beat;
    logic flush;
    logic out_valid;
    logic out_ready = 1'b1;
    logic [7:0] out_data;

    int seed = 32'h0154_8455;
    // precomputed out_ready pattern, about three cycles in four ready
    logic ready_pat [READY_PAT_LEN];
    int ready_idx = 0;
    logic ready_random = 1'b0;

    // model state
    logic [7:0] slot_w [SLICES];
    ternary_pkg::act_t slot_a [SLICES];
    int slot_cnt;
    ternary_pkg::acc_t model_acc [DEPTH];
    logic [7:0] exp_q [$];
    logic [7:0] exp_byte;
    int rcv_count;
    int value_errs;
    int other_errs;

    ternary_matmul #(.SLICES(SLICES)) ternary_matmul_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .flush     (flush),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        out_ready <= ready_random ? ready_pat[ready_idx] : 1'b1;
        ready_idx <= (ready_idx + 1) % READY_PAT_LEN;
    end

    // weight of flag k: base-3 digit 4-k, digit 2 means -1, codes past 242 are +1
    function automatic int trit_weight(int code, int k);
        int digit;
        int p;
        if (code > ternary_pkg::MAX_PACKED_CODE) begin
            return 1;
        end
        p = 1;
        for (int n = 0; n < ternary_pkg::TRITS_PER_BYTE - 1 - k; n++) begin
            p = p * 3;
        end
        digit = (code / p) % 3;
        return (digit == 2) ? -1 : digit;
    endfunction

    // outer product of the collected group into the model, 17-bit wrap
    task automatic apply_group();
        int w;
        for (int i = 0; i < ROWS; i++) begin
            for (int j = 0; j < SLICES; j++) begin
                w = trit_weight(int'(slot_w[i / ternary_pkg::TRITS_PER_BYTE]),
                                i % ternary_pkg::TRITS_PER_BYTE);
                model_acc[i*SLICES+j] = model_acc[i*SLICES+j]
                                        + ternary_pkg::acc_t'(w * int'(slot_a[j]));
            end
        end
    endtask

    task automatic send_beat(int w, int a);
        @(posedge clk);
        in_valid <= 1'b1;
        in_beat.weights <= 8'(w);
        in_beat.act <= ternary_pkg::act_t'(a);
        slot_w[slot_cnt] = 8'(w);
        slot_a[slot_cnt] = ternary_pkg::act_t'(a);
        slot_cnt++;
        if (slot_cnt == SLICES) begin
            apply_group();
            slot_cnt = 0;
        end
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    // one-cycle flush, then the model takes its snapshot on the same edge as the DUT
    task automatic do_flush();
        @(posedge clk);
        in_valid <= 1'b0;
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        exp_q.delete();
        for (int n = 0; n < DEPTH; n++) begin
            exp_q.push_back(model_acc[n][ternary_pkg::OUT_LSB +: 8]);
            model_acc[n] = '0;
        end
        // partial group is dropped
        slot_cnt = 0;
        rcv_count = 0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (out_valid && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (!out_valid) else begin
            $display("%0t: readout drain still busy after %0d cycles", $time, cycles);
            other_errs++;
        end
        assert (rcv_count == DEPTH && exp_q.size() == 0) else begin
            $display("CHECK FAILED %0t: %0d bytes read, expected %0d", $time, rcv_count, DEPTH);
            value_errs++;
        end
    endtask

    // transfer happens on the next rising edge when both are high here
    always @(negedge clk) begin
        if (!reset && out_valid && out_ready) begin
            assert (exp_q.size() > 0) else begin
                $display("%0t: byte transferred when none was expected", $time);
                other_errs++;
            end
            if (exp_q.size() > 0) begin
                exp_byte = exp_q.pop_front();
                assert (out_data == exp_byte) else begin
                    $display("CHECK FAILED %0t: entry %0d got %02h expected %02h",
                             $time, rcv_count, out_data, exp_byte);
                    value_errs++;
                end
                rcv_count++;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_beat = '0;
        flush = 1'b0;
        slot_cnt = 0;
        rcv_count = 0;
        value_errs = 0;
        other_errs = 0;
        for (int n = 0; n < DEPTH; n++) begin
            model_acc[n] = '0;
        end
        for (int n = 0; n < READY_PAT_LEN; n++) begin
            ready_pat[n] = ($random(seed) & 3) != 0;
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        idle(2);

        // every code 0..255, three repeats so zero, +1 and -1 give distinct bytes
        for (int c = 0; c < 256; c += SLICES) begin
            repeat (DECODE_REPS) begin
                for (int s = 0; s < SLICES; s++) begin
                    send_beat((c + s) % 256, (s % 2 == 0) ? 100 : -100);
                end
            end
            idle(2);
            do_flush();
            wait_drain();
        end

        // random groups with back-pressure from here on
        ready_random = 1'b1;
        for (int g = 0; g < N_RAND; g++) begin
            for (int s = 0; s < SLICES; s++) begin
                send_beat($random(seed) & 255, $random(seed));
            end
        end
        idle(2);
        do_flush();
        wait_drain();

        // all +1 weights with extreme activations, columns wrap both ways
        for (int g = 0; g < N_WRAP; g++) begin
            for (int s = 0; s < SLICES; s++) begin
                send_beat(($random(seed) & 1) ? 121 : 255, (s % 2 == 0) ? 127 : -128);
            end
        end
        idle(2);
        do_flush();
        wait_drain();

        // back to back flush reads all zero
        do_flush();
        wait_drain();

        // partial group is dropped, next group starts at slice 0
        for (int s = 0; s < SLICES - 1; s++) begin
            send_beat($random(seed) & 255, $random(seed));
        end
        idle(2);
        do_flush();
        wait_drain();
        for (int s = 0; s < SLICES; s++) begin
            send_beat($random(seed) & 255, $random(seed));
        end
        idle(2);
        do_flush();
        wait_drain();

        // second flush lands while the first snapshot is still draining
        for (int s = 0; s < SLICES; s++) begin
            send_beat($random(seed) & 255, $random(seed));
        end
        idle(2);
        do_flush();
        for (int s = 0; s < SLICES; s++) begin
            send_beat($random(seed) & 255, $random(seed));
        end
        idle(2);
        do_flush();
        wait_drain();

        idle(4);
        $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ternary_matmul.f
ternary_pkg.sv
trit_unpack.sv
operand_collector.sv
mac_array.sv
readout_queue.sv
ternary_matmul.sv
ternary_matmul_checker.sv
tb_ternary_matmul.sv

// File: Makefile
# Verilator build and run of the ternary_matmul testbench

VERILATOR ?= verilator
TOP       ?= tb_ternary_matmul
FILELIST  ?= ternary_matmul.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
